// File: rtl/packet_buffer_top.sv
`default_nettype none

module packet_buffer_top (
    input  logic                               clk,
    input  logic                               reset,
    input  pkt_types_pkg::packet_beat_t        dp_in,
    input  pkt_types_pkg::packet_beat_t        edge_in,
    input  logic                               full,
    input  logic [pkt_cfg_pkg::ITER_W-1:0]     replay_iter,
    input  logic                               replay_flag,
    output pkt_types_pkg::packet_beat_t        out_beat,
    output logic                               done,
    output logic [pkt_cfg_pkg::DROP_CNT_W-1:0] edge_drop_count
);

    pkt_types_pkg::packet_beat_t   lane_dp   [pkt_cfg_pkg::LANES];
    pkt_types_pkg::packet_beat_t   lane_edge [pkt_cfg_pkg::LANES];
    pkt_types_pkg::packet_beat_t   rd_beat   [pkt_cfg_pkg::LANES];
    logic [pkt_cfg_pkg::LANES-1:0] grant;
    logic [pkt_cfg_pkg::LANES-1:0] nonempty;
    logic [pkt_cfg_pkg::LANES-1:0] lane_done;

    packet_dispatch u_dispatch (
        .clk             (clk),
        .reset           (reset),
        .dp_in           (dp_in),
        .edge_in         (edge_in),
        .lane_dp         (lane_dp),
        .lane_edge       (lane_edge),
        .edge_drop_count (edge_drop_count)
    );

    // ======================================================================
    // Lane controllers
    // ======================================================================
    for (genvar i = 0; i < pkt_cfg_pkg::LANES; i++) begin : g_lane
        packet_cntl u_cntl (
            .clk         (clk),
            .reset       (reset),
            .dp_beat     (lane_dp[i]),
            .edge_beat   (lane_edge[i]),
            .grant       (grant[i]),
            .replay_iter (replay_iter),
            .replay_flag (replay_flag),
            .nonempty    (nonempty[i]),
            .rd_beat     (rd_beat[i]),
            .lane_done   (lane_done[i])
        );
    end

    packet_drain u_drain (
        .clk      (clk),
        .reset    (reset),
        .full     (full),
        .nonempty (nonempty),
        .rd_beat  (rd_beat),
        .grant    (grant),
        .out_beat (out_beat)
    );

    assign done = &lane_done;                           // All lanes stopped.

endmodule

`default_nettype wire

// File: rtl/packet_cntl.sv
`default_nettype none

module packet_cntl (
    input  logic                           clk,
    input  logic                           reset,
    input  pkt_types_pkg::packet_beat_t    dp_beat,
    input  pkt_types_pkg::packet_beat_t    edge_beat,
    input  logic                           grant,
    input  logic [pkt_cfg_pkg::ITER_W-1:0] replay_iter,
    input  logic                           replay_flag,
    output logic                           nonempty,
    output pkt_types_pkg::packet_beat_t    rd_beat,
    output logic                           lane_done
);

    typedef enum logic {
        ST_STREAM,
        ST_DONE
    } state_t;

    state_t                           state;
    logic [pkt_cfg_pkg::ADDR_W-1:0]   wr_ptr;
    logic [pkt_cfg_pkg::ADDR_W-1:0]   rd_ptr;
    logic                             streaming;
    logic                             wr_in;
    logic                             wr_en;
    logic                             rd_en;
    logic                             rd_valid;
    logic                             replay_rewind;
    logic                             replay_stop;
    pkt_types_pkg::sram_req_t         sram_req;
    logic [pkt_cfg_pkg::PACKET_W-1:0] sram_rd_data;

    // ======================================================================
    // Request decode
    // ======================================================================
    assign streaming     = (state == ST_STREAM);
    assign wr_in         = dp_beat.valid || edge_beat.valid;
    assign wr_en         = streaming && wr_in;
    assign rd_en         = streaming && grant;
    assign replay_rewind = replay_flag && (replay_iter != '0);
    assign replay_stop   = replay_flag && (replay_iter == '0);

    // A writing lane hides itself from the drain for that cycle.
    assign nonempty  = streaming && !wr_in && (rd_ptr != wr_ptr);
    assign lane_done = (state == ST_DONE);

    always_comb begin
        sram_req.we   = wr_en;
        sram_req.addr = wr_en ? wr_ptr : rd_ptr;
        sram_req.data = dp_beat.valid ? dp_beat.packet : edge_beat.packet; // Datapath wins.
    end

    // ======================================================================
    // State and pointers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_STREAM;
        end else if (streaming && replay_stop) begin
            state <= ST_DONE;                       // Sticky until reset.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;                      // Lines up with SRAM output.
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;            // Wraps over the oldest word.
            end
            if (replay_rewind) begin
                rd_ptr <= '0;                       // Stored data is kept for replay.
            end else if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_comb begin
        rd_beat.valid  = rd_valid;
        rd_beat.packet = sram_rd_data;
    end

    packet_sram u_sram (
        .clk     (clk),
        .req     (sram_req),
        .rd_en   (rd_en),
        .rd_data (sram_rd_data)
    );

    // The drain must only pick lanes that advertise nonempty.
    assert property (@(posedge clk) disable iff (reset) grant |-> streaming)
        else $error("packet_cntl: grant to a done lane");

    assert property (@(posedge clk) disable iff (reset) grant |-> !wr_in)
        else $error("packet_cntl: grant during a lane write");

endmodule

`default_nettype wire

// File: rtl/packet_dispatch.sv
`default_nettype none

module packet_dispatch (
    input  logic                               clk,
    input  logic                               reset,
    input  pkt_types_pkg::packet_beat_t        dp_in,
    input  pkt_types_pkg::packet_beat_t        edge_in,
    output pkt_types_pkg::packet_beat_t        lane_dp   [pkt_cfg_pkg::LANES],
    output pkt_types_pkg::packet_beat_t        lane_edge [pkt_cfg_pkg::LANES],
    output logic [pkt_cfg_pkg::DROP_CNT_W-1:0] edge_drop_count
);

    logic [pkt_cfg_pkg::LANE_W-1:0] dp_lane;
    logic [pkt_cfg_pkg::LANE_W-1:0] edge_lane;
    logic                           edge_drop;

    // Destination lane from the top bits.
    assign dp_lane   = dp_in.packet[pkt_cfg_pkg::PACKET_W-1:pkt_cfg_pkg::LANE_LSB];
    assign edge_lane = edge_in.packet[pkt_cfg_pkg::PACKET_W-1:pkt_cfg_pkg::LANE_LSB];

    // ======================================================================
    // Lane fan-out
    // ======================================================================
    always_comb begin
        for (int i = 0; i < pkt_cfg_pkg::LANES; i++) begin
            lane_dp[i].packet   = dp_in.packet;
            lane_dp[i].valid    = dp_in.valid && (dp_lane == i);
            lane_edge[i].packet = edge_in.packet;
            lane_edge[i].valid  = edge_in.valid && (edge_lane == i);
        end
    end

    // The lane controller keeps the datapath packet and drops this edge packet.
    assign edge_drop = dp_in.valid && edge_in.valid && (dp_lane == edge_lane);

    always_ff @(posedge clk) begin
        if (reset) begin
            edge_drop_count <= '0;
        end else if (edge_drop && (edge_drop_count != '1)) begin
            edge_drop_count <= edge_drop_count + 1'b1;  // Saturates.
        end
    end

endmodule

`default_nettype wire

// File: rtl/packet_drain.sv
`default_nettype none

module packet_drain (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          full,
    input  logic [pkt_cfg_pkg::LANES-1:0] nonempty,
    input  pkt_types_pkg::packet_beat_t   rd_beat [pkt_cfg_pkg::LANES],
    output logic [pkt_cfg_pkg::LANES-1:0] grant,
    output pkt_types_pkg::packet_beat_t   out_beat
);

    logic [pkt_cfg_pkg::LANE_W-1:0] rr_ptr;      // Last granted lane.
    logic [pkt_cfg_pkg::LANE_W-1:0] pick;
    logic [pkt_cfg_pkg::LANE_W-1:0] sel_q;       // Lane whose beat arrives now.
    logic [pkt_cfg_pkg::LANES-1:0]  rd_valid;

    // ======================================================================
    // Round-robin grant
    // ======================================================================
    // Search starts after the last granted lane and ends on that lane itself.
    always_comb begin
        int cand;
        grant = '0;
        pick  = rr_ptr;
        for (int k = 1; k <= pkt_cfg_pkg::LANES; k++) begin
            cand = (int'(rr_ptr) + k) % pkt_cfg_pkg::LANES;
            if (!full && (grant == '0) && nonempty[cand]) begin
                grant[cand] = 1'b1;
                pick        = cand[pkt_cfg_pkg::LANE_W-1:0];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < pkt_cfg_pkg::LANES; i++) begin
            rd_valid[i] = rd_beat[i].valid;
        end
    end

    // ======================================================================
    // Output merge
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr         <= '1;                     // Lane 0 goes first.
            sel_q          <= '0;
            out_beat.valid <= 1'b0;
        end else begin
            if (grant != '0) begin
                rr_ptr <= pick;
            end
            sel_q          <= pick;
            out_beat.valid <= rd_valid[sel_q];
        end
    end

    always_ff @(posedge clk) begin
        out_beat.packet <= rd_beat[sel_q].packet;
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("packet_drain: more than one grant");

    assert property (@(posedge clk) disable iff (reset) $onehot0(rd_valid))
        else $error("packet_drain: more than one lane returned data");

    // Each grant comes back from exactly that lane one cycle later.
    assert property (@(posedge clk) disable iff (reset)
                     (grant != '0) |=> (rd_valid == $past(grant)))
        else $error("packet_drain: read data does not follow grant");

endmodule

`default_nettype wire

// File: rtl/packet_sram.sv
`default_nettype none

module packet_sram (
    input  logic                             clk,
    input  pkt_types_pkg::sram_req_t         req,
    input  logic                             rd_en,
    output logic [pkt_cfg_pkg::PACKET_W-1:0] rd_data
);

    logic [pkt_cfg_pkg::PACKET_W-1:0] mem [pkt_cfg_pkg::DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.data;
        end
    end

    // Registered read, data shows up the cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[req.addr];
        end
    end

    // Single port, so the controller and the drain must keep reads off write cycles.
    assert property (@(posedge clk) !(req.we && rd_en))
        else $error("packet_sram: write and read in the same cycle");

endmodule

`default_nettype wire

// File: rtl/pkt_cfg_pkg.sv
`default_nettype none

package pkt_cfg_pkg;

    // ======================================================================
    // Lane partitioning
    // ======================================================================
    localparam int LANES    = 4;                        // Packet controllers.
    localparam int LANE_W   = $clog2(LANES);            // Destination lane field.

    // ======================================================================
    // Packet word and lane buffer
    // ======================================================================
    localparam int PACKET_W = 32;
    localparam int LANE_LSB = PACKET_W - LANE_W;        // Lane field sits on top.
    localparam int DEPTH    = 16;                       // Lines per lane SRAM.
    localparam int ADDR_W   = $clog2(DEPTH);

    // Replay control and statistics.
    localparam int MAX_REPLAY = 8;
    localparam int ITER_W     = $clog2(MAX_REPLAY + 1); // Holds 0 to MAX_REPLAY.
    localparam int DROP_CNT_W = 16;

endpackage

`default_nettype wire

// File: rtl/pkt_types_pkg.sv
`default_nettype none

package pkt_types_pkg;

    // ======================================================================
    // Packet beat
    // ======================================================================
    // Datapath and edge packets share this layout. The destination lane
    // lives in the top LANE_W bits of the packet word.
    typedef struct packed {
        logic                             valid;   // One-cycle strobe.
        logic [pkt_cfg_pkg::PACKET_W-1:0] packet;
    } packet_beat_t;

    // ======================================================================
    // Lane SRAM request
    // ======================================================================
    // One address serves both the write and the read port.
    typedef struct packed {
        logic                             we;      // Active high write.
        logic [pkt_cfg_pkg::ADDR_W-1:0]   addr;
        logic [pkt_cfg_pkg::PACKET_W-1:0] data;
    } sram_req_t;

endpackage

`default_nettype wire

// File: sim.f
rtl/pkt_cfg_pkg.sv
rtl/pkt_types_pkg.sv
rtl/packet_sram.sv
rtl/packet_cntl.sv
rtl/packet_dispatch.sv
rtl/packet_drain.sv
rtl/packet_buffer_top.sv
sim/tb_packet_buffer.sv

// File: sim/tb_packet_buffer.sv
`default_nettype none

module tb_packet_buffer;

    timeunit 1ns;
    timeprecision 100ps;

    logic                               clk;
    logic                               reset;
    pkt_types_pkg::packet_beat_t        dp_in;
    pkt_types_pkg::packet_beat_t        edge_in;
    logic                               full;
    logic [pkt_cfg_pkg::ITER_W-1:0]     replay_iter;
    logic                               replay_flag;
    pkt_types_pkg::packet_beat_t        out_beat;
    logic                               done;
    logic [pkt_cfg_pkg::DROP_CNT_W-1:0] edge_drop_count;

    logic [pkt_cfg_pkg::PACKET_W-1:0] stored [pkt_cfg_pkg::LANES][$]; // Lane contents in write order.
    int rd_idx [pkt_cfg_pkg::LANES] = '{default: 0};                  // Next packet expected.
    int beats_seen = 0;
    int drop_model = 0;                                               // Edge packets lost so far.
    int checks     = 0;
    int errors     = 0;

    packet_buffer_top u_dut (
        .clk             (clk),
        .reset           (reset),
        .dp_in           (dp_in),
        .edge_in         (edge_in),
        .full            (full),
        .replay_iter     (replay_iter),
        .replay_flag     (replay_flag),
        .out_beat        (out_beat),
        .done            (done),
        .edge_drop_count (edge_drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // Checks and model helpers
    // ======================================================================
    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    function automatic int lane_of(input logic [pkt_cfg_pkg::PACKET_W-1:0] pkt);
        return int'(pkt[pkt_cfg_pkg::PACKET_W-1:pkt_cfg_pkg::LANE_LSB]);
    endfunction

    function automatic logic [31:0] make_packet(input int lane);
        logic [31:0] pkt;
        pkt = $urandom;
        pkt[pkt_cfg_pkg::PACKET_W-1:pkt_cfg_pkg::LANE_LSB] = lane[pkt_cfg_pkg::LANE_W-1:0];
        return pkt;
    endfunction

    function automatic bit all_read();
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < pkt_cfg_pkg::LANES; i++) begin
            if (rd_idx[i] != stored[i].size()) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Each output beat must be the next unread packet of its own lane.
    always @(negedge clk) begin
        int lane;
        if (!reset && out_beat.valid) begin
            lane = lane_of(out_beat.packet);
            beats_seen++;
            expect_true(rd_idx[lane] < stored[lane].size(),
                        "output beat with nothing left to read");
            if (rd_idx[lane] < stored[lane].size()) begin
                expect_eq("out_beat.packet", out_beat.packet, stored[lane][rd_idx[lane]]);
                rd_idx[lane]++;
            end
        end
    end

    // One input cycle; an edge packet for the lane of the datapath packet is lost.
    task automatic send(input logic dp_v, input logic [31:0] dp_pkt,
                        input logic edge_v, input logic [31:0] edge_pkt);
        dp_in   = '{valid: dp_v, packet: dp_pkt};
        edge_in = '{valid: edge_v, packet: edge_pkt};
        if (dp_v) begin
            stored[lane_of(dp_pkt)].push_back(dp_pkt);
        end
        if (edge_v) begin
            if (dp_v && lane_of(dp_pkt) == lane_of(edge_pkt)) begin
                drop_model++;
            end else begin
                stored[lane_of(edge_pkt)].push_back(edge_pkt);
            end
        end
        @(posedge clk);
        #1;
        dp_in.valid   = 1'b0;
        edge_in.valid = 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (!all_read() && cycles < 200) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        expect_true(all_read(), {"timed out waiting for all packets in ", what});
        repeat (10) @(posedge clk);                     // Room for stray beats.
        #1;
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_state();
        for (int i = 0; i < 20; i++) begin
            expect_eq("out_beat.valid after reset", out_beat.valid, 1'b0);
            expect_eq("done after reset", done, 1'b0);
            @(posedge clk);
            #1;
        end
        expect_eq("edge_drop_count after reset", edge_drop_count, 0);
    endtask

    task automatic test_lane_order();
        int          start;
        logic [31:0] pkt;
        for (int r = 0; r < 3; r++) begin
            start = $urandom % pkt_cfg_pkg::LANES;
            for (int j = 0; j < pkt_cfg_pkg::LANES; j++) begin
                pkt = make_packet((start + j) % pkt_cfg_pkg::LANES);
                if ($urandom % 2) begin
                    send(1'b1, pkt, 1'b0, '0);
                end else begin
                    send(1'b0, '0, 1'b1, pkt);
                end
            end
        end
        wait_drained("lane order test");
    endtask

    task automatic test_write_priority();
        int lane_a;
        int lane_b;
        lane_a = $urandom % pkt_cfg_pkg::LANES;
        lane_b = (lane_a + 1 + $urandom % 3) % pkt_cfg_pkg::LANES;
        send(1'b1, make_packet(lane_a), 1'b1, make_packet(lane_a));
        expect_eq("edge_drop_count after collision", edge_drop_count, drop_model);
        send(1'b1, make_packet(lane_a), 1'b1, make_packet(lane_b));
        expect_eq("edge_drop_count after split lanes", edge_drop_count, drop_model);
        wait_drained("write priority test");
    endtask

    task automatic test_back_pressure();
        int base;
        int cycles;
        full = 1'b1;
        base = beats_seen;
        for (int i = 0; i < 2 * pkt_cfg_pkg::LANES; i++) begin
            send(1'b1, make_packet(i % pkt_cfg_pkg::LANES), 1'b0, '0);
        end
        repeat (5) @(posedge clk);
        #1;
        expect_eq("beats while held full", beats_seen, base);
        full   = 1'b0;
        cycles = 0;
        while (beats_seen < base + 2 && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        expect_true(beats_seen >= base + 2, "timed out waiting for the first drained beats");
        full = 1'b1;                                    // Mid-drain stall.
        base = beats_seen;
        repeat (20) @(posedge clk);
        #1;
        expect_true(beats_seen - base <= 2, "more than two beats arrived after full rose");
        full = 1'b0;
        wait_drained("back-pressure test");
    endtask

    task automatic test_replay();
        replay_iter = 3;
        replay_flag = 1'b1;
        for (int i = 0; i < pkt_cfg_pkg::LANES; i++) begin
            rd_idx[i] = 0;                              // Everything streams again.
        end
        @(posedge clk);
        #1;
        replay_flag = 1'b0;
        wait_drained("replay test");
    endtask

    task automatic test_done();
        replay_iter = 0;
        replay_flag = 1'b1;
        @(posedge clk);
        #1;
        replay_flag = 1'b0;
        expect_eq("done after stop strobe", done, 1'b1);
        for (int i = 0; i < 8; i++) begin
            dp_in = '{valid: 1'b1, packet: make_packet(i % pkt_cfg_pkg::LANES)}; // Not stored.
            @(posedge clk);
            #1;
        end
        dp_in.valid = 1'b0;
        for (int i = 0; i < 20; i++) begin
            expect_eq("done while stopped", done, 1'b1);
            expect_eq("out_beat.valid while stopped", out_beat.valid, 1'b0);
            @(posedge clk);
            #1;
        end
        reset = 1'b1;
        @(posedge clk);
        #1;
        reset = 1'b0;
        expect_eq("done after second reset", done, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h26b9));
        reset       = 1'b1;
        dp_in       = '0;
        edge_in     = '0;
        full        = 1'b0;
        replay_iter = '0;
        replay_flag = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_lane_order();
        test_write_priority();
        test_back_pressure();
        test_replay();
        test_done();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
